// File: include/exe_cfg.svh
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath widths
`define EXE_XLEN 32
`define EXE_ID_W 64
`define EXE_FUN_W 5

// one extra bit so unsigned operands can carry a sign
`define EXE_MD_W (`EXE_XLEN + 1)

// one quotient or product bit per cycle
`define EXE_MD_CYCLES `EXE_MD_W

`endif

// File: hdl/exe_pkg.sv
`include "exe_cfg.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   word_t;
    typedef logic [`EXE_ID_W-1:0]   inst_id_t;
    typedef logic [`EXE_MD_W-1:0]   md_word_t;
    typedef logic [2*`EXE_MD_W-1:0] md_prod_t;

    typedef enum logic [`EXE_FUN_W-1:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        JALR,
        COPY1,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        MUL,
        MULH,
        MULHU,
        MULHSU,
        DIV,
        DIVU,
        REM,
        REMU,
        NOP
    } exe_fun_e;

    typedef enum logic [1:0] {idle, busy, done} md_state_e;

    localparam inst_id_t INST_ID_NONE = '1; // ids never reach all ones

    function automatic md_word_t md_mag(input md_word_t v, input logic is_signed);
        return (is_signed && v[`EXE_MD_W-1]) ? -v : v;
    endfunction

endpackage

// File: hdl/seq_divider.sv
`include "exe_cfg.svh"

module seq_divider
    import exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     is_signed,
    input  md_word_t dividend,
    input  md_word_t divisor,
    output logic     ready,
    output logic     valid,
    output md_word_t quotient,
    output md_word_t remainder
);
    localparam int W     = `EXE_MD_W;
    localparam int CNT_W = $clog2(`EXE_MD_CYCLES);

    md_state_e        state;
    logic [CNT_W-1:0] cnt;
    md_word_t         quo_q;    // dividend bits out, quotient bits in
    md_word_t         rem_q;
    md_word_t         den_q;    // divisor magnitude
    logic             neg_quo;
    logic             neg_rem;

    logic [W:0]       rem_sh;
    logic [W:0]       diff;
    logic             fits;
    md_word_t         quo_next;
    md_word_t         rem_next;
    logic             last;

    // one restoring step
    assign rem_sh   = {rem_q, quo_q[W-1]};
    assign diff     = rem_sh - {1'b0, den_q};
    assign fits     = rem_sh >= {1'b0, den_q};
    assign rem_next = fits ? diff[W-1:0] : rem_sh[W-1:0];
    assign quo_next = {quo_q[W-2:0], fits};
    assign last     = cnt == CNT_W'(`EXE_MD_CYCLES - 1);

    assign ready = state != busy;
    assign valid = state == done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                busy: begin
                    cnt <= cnt + 1'b1;
                    if (last)
                        state <= done;
                end
                default: begin
                    cnt   <= '0;
                    state <= start ? busy : idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            quo_q   <= md_mag(dividend, is_signed);
            den_q   <= md_mag(divisor, is_signed);
            rem_q   <= '0;
            // x / 0 keeps the all-ones quotient of the raw loop
            neg_quo <= is_signed && (dividend[W-1] ^ divisor[W-1]) && (divisor != '0);
            neg_rem <= is_signed && dividend[W-1];   // remainder takes dividend sign
        end else if (state == busy) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
            if (last) begin
                quotient  <= neg_quo ? -quo_next : quo_next;
                remainder <= neg_rem ? -rem_next : rem_next;
            end
        end
    end

    // ready stays low for the whole division, then returns with the result
    assert property (@(posedge clk) disable iff (!rst_n)
        start && ready |=> !ready [* `EXE_MD_CYCLES] ##1 (ready && valid));

endmodule

// File: hdl/seq_multiplier.sv
`include "exe_cfg.svh"

module seq_multiplier
    import exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     is_signed,
    input  md_word_t multiplicand,
    input  md_word_t multiplier,
    output logic     ready,
    output logic     valid,
    output md_prod_t product
);
    localparam int W     = `EXE_MD_W;
    localparam int CNT_W = $clog2(`EXE_MD_CYCLES);

    md_state_e        state;
    logic [CNT_W-1:0] cnt;
    md_prod_t         acc_q;
    md_prod_t         mcand_q;  // shifts left each step
    md_word_t         mplier_q; // shifts right each step
    logic             neg_q;
    md_prod_t         acc_next;
    logic             last;

    assign acc_next = mplier_q[0] ? acc_q + mcand_q : acc_q;
    assign last     = cnt == CNT_W'(`EXE_MD_CYCLES - 1);

    assign ready = state != busy;
    assign valid = state == done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                busy: begin
                    cnt <= cnt + 1'b1;
                    if (last)
                        state <= done;
                end
                default: begin
                    cnt   <= '0;
                    state <= start ? busy : idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            acc_q    <= '0;
            mcand_q  <= {{W{1'b0}}, md_mag(multiplicand, is_signed)};
            mplier_q <= md_mag(multiplier, is_signed);
            neg_q    <= is_signed && (multiplicand[W-1] ^ multiplier[W-1]);
        end else if (state == busy) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            if (last)
                product <= neg_q ? -acc_next : acc_next;
        end
    end

    // ready stays low for the whole run, then returns with the result
    assert property (@(posedge clk) disable iff (!rst_n)
        start && ready |=> !ready [* `EXE_MD_CYCLES] ##1 (ready && valid));

endmodule

// File: hdl/execute_stage.sv
`include "exe_cfg.svh"

module execute_stage
    import exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exe_valid,
    input  word_t    exe_pc,
    input  inst_id_t exe_inst_id,
    input  exe_fun_e exe_fun,
    input  word_t    op1_data,
    input  word_t    op2_data,
    input  word_t    imm_b_sext,
    input  word_t    imm_j_sext,
    input  logic     jmp_pc_flg,
    input  logic     jmp_reg_flg,
    input  logic     pipeline_flush,
    output logic     exe_mem_valid,
    output word_t    exe_mem_pc,
    output inst_id_t exe_mem_inst_id,
    output word_t    exe_mem_alu_out,
    output logic     branch_taken,
    output word_t    branch_target,
    output logic     calc_stall_flg,
    output logic     div_start,
    input  logic     div_ready,
    input  logic     div_valid,
    output logic     div_signed,
    output md_word_t div_dividend,
    output md_word_t div_divisor,
    input  md_word_t div_quotient,
    input  md_word_t div_remainder,
    output logic     mul_start,
    input  logic     mul_ready,
    input  logic     mul_valid,
    output logic     mul_signed,
    output md_word_t mul_multiplicand,
    output md_word_t mul_multiplier,
    input  md_prod_t mul_product
);
    localparam int XLEN    = `EXE_XLEN;
    localparam int SHAMT_W = $clog2(XLEN);

    logic     is_div;
    logic     is_mul;
    logic     is_md;
    logic     calc_started;     // unit running for this instruction
    logic     is_calculated;    // saved_result belongs to saved_inst_id
    inst_id_t saved_inst_id;
    word_t    saved_result;
    word_t    md_result;
    logic     result_held;
    logic     calc_valid;
    logic     capture;
    logic     br_cond;

    assign is_div      = exe_fun inside {DIV, DIVU, REM, REMU};
    assign is_mul      = exe_fun inside {MUL, MULH, MULHU, MULHSU};
    assign is_md       = is_div || is_mul;
    assign result_held = is_calculated && (saved_inst_id == exe_inst_id);

    assign div_signed   = exe_fun inside {DIV, REM};
    assign div_dividend = div_signed ? {op1_data[XLEN-1], op1_data} : {1'b0, op1_data};
    assign div_divisor  = div_signed ? {op2_data[XLEN-1], op2_data} : {1'b0, op2_data};
    assign div_start    = exe_valid && is_div && !result_held && !calc_started &&
                          !pipeline_flush && div_ready;

    assign mul_signed       = exe_fun inside {MUL, MULH, MULHSU};
    assign mul_multiplicand = mul_signed ? {op1_data[XLEN-1], op1_data} : {1'b0, op1_data};
    assign mul_multiplier   = (mul_signed && exe_fun != MULHSU) ?
                              {op2_data[XLEN-1], op2_data} : {1'b0, op2_data};
    assign mul_start        = exe_valid && is_mul && !result_held && !calc_started &&
                              !pipeline_flush && mul_ready;

    assign calc_valid = (is_div && div_valid) || (is_mul && mul_valid);
    assign capture    = exe_valid && is_md && !pipeline_flush && calc_started && calc_valid;

    always_comb begin
        case (exe_fun)
            DIV, DIVU: md_result = div_quotient[XLEN-1:0];
            REM, REMU: md_result = div_remainder[XLEN-1:0];
            MUL:       md_result = mul_product[XLEN-1:0];
            default:   md_result = mul_product[2*XLEN-1:XLEN]; // high word
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            calc_started  <= 1'b0;
            is_calculated <= 1'b0;
            saved_inst_id <= INST_ID_NONE;
        end else if (pipeline_flush || !exe_valid || !is_md) begin
            calc_started  <= 1'b0;   // a running unit finishes unobserved
            is_calculated <= 1'b0;
        end else if (capture) begin
            calc_started  <= 1'b0;
            is_calculated <= 1'b1;
            saved_inst_id <= exe_inst_id;
        end else if (!result_held && !calc_started) begin
            calc_started  <= div_start || mul_start;
            is_calculated <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            saved_result <= md_result;
    end

    always_comb begin
        case (exe_fun)
            ADD:     exe_mem_alu_out = op1_data + op2_data;
            SUB:     exe_mem_alu_out = op1_data - op2_data;
            AND:     exe_mem_alu_out = op1_data & op2_data;
            OR:      exe_mem_alu_out = op1_data | op2_data;
            XOR:     exe_mem_alu_out = op1_data ^ op2_data;
            SLL:     exe_mem_alu_out = op1_data << op2_data[SHAMT_W-1:0];
            SRL:     exe_mem_alu_out = op1_data >> op2_data[SHAMT_W-1:0];
            SRA:     exe_mem_alu_out = word_t'($signed(op1_data) >>> op2_data[SHAMT_W-1:0]);
            SLT:     exe_mem_alu_out = word_t'($signed(op1_data) < $signed(op2_data));
            SLTU:    exe_mem_alu_out = word_t'(op1_data < op2_data);
            JALR:    exe_mem_alu_out = (op1_data + op2_data) & ~word_t'(1);
            COPY1:   exe_mem_alu_out = op1_data;
            DIV, DIVU, REM, REMU,
            MUL, MULH, MULHU, MULHSU:
                     exe_mem_alu_out = saved_result;
            default: exe_mem_alu_out = '0;
        endcase
    end

    always_comb begin
        case (exe_fun)
            BEQ:     br_cond = op1_data == op2_data;
            BNE:     br_cond = op1_data != op2_data;
            BLT:     br_cond = $signed(op1_data) < $signed(op2_data);
            BGE:     br_cond = $signed(op1_data) >= $signed(op2_data);
            BLTU:    br_cond = op1_data < op2_data;
            BGEU:    br_cond = op1_data >= op2_data;
            default: br_cond = 1'b0;
        endcase
    end

    assign branch_taken  = exe_valid && (jmp_pc_flg || jmp_reg_flg || br_cond);
    assign branch_target = jmp_pc_flg  ? exe_pc + imm_j_sext :
                           jmp_reg_flg ? op1_data + op2_data :
                                         exe_pc + imm_b_sext;

    assign calc_stall_flg  = exe_valid && is_md && !result_held;
    assign exe_mem_valid   = exe_valid && !calc_stall_flg;
    assign exe_mem_pc      = exe_pc;
    assign exe_mem_inst_id = exe_inst_id;

    // a start is only issued to an idle unit, which then drops ready
    assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> div_ready ##1 !div_ready);
    assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> mul_ready ##1 !mul_ready);

    // result pulses come only from a unit that was running
    assert property (@(posedge clk) disable iff (!rst_n)
        div_valid |-> $past(!div_ready));
    assert property (@(posedge clk) disable iff (!rst_n)
        mul_valid |-> $past(!mul_ready));

endmodule

// File: hdl/exe_core.sv
module exe_core
    import exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exe_valid,
    input  word_t    exe_pc,
    input  inst_id_t exe_inst_id,
    input  exe_fun_e exe_fun,
    input  word_t    op1_data,
    input  word_t    op2_data,
    input  word_t    imm_b_sext,
    input  word_t    imm_j_sext,
    input  logic     jmp_pc_flg,
    input  logic     jmp_reg_flg,
    input  logic     pipeline_flush,
    output logic     exe_mem_valid,
    output word_t    exe_mem_pc,
    output inst_id_t exe_mem_inst_id,
    output word_t    exe_mem_alu_out,
    output logic     branch_taken,
    output word_t    branch_target,
    output logic     calc_stall_flg
);
    logic     div_start;
    logic     div_ready;
    logic     div_valid;
    logic     div_signed;
    md_word_t div_dividend;
    md_word_t div_divisor;
    md_word_t div_quotient;
    md_word_t div_remainder;

    logic     mul_start;
    logic     mul_ready;
    logic     mul_valid;
    logic     mul_signed;
    md_word_t mul_multiplicand;
    md_word_t mul_multiplier;
    md_prod_t mul_product;

    execute_stage execute_stage_inst (.*);

    seq_divider seq_divider_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .ready     (div_ready),
        .valid     (div_valid),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    seq_multiplier seq_multiplier_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .is_signed    (mul_signed),
        .multiplicand (mul_multiplicand),
        .multiplier   (mul_multiplier),
        .ready        (mul_ready),
        .valid        (mul_valid),
        .product      (mul_product)
    );

endmodule

// File: verif/tb_exe_core.sv
`include "exe_cfg.svh"

module tb_exe_core
    import exe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ALU      = 8;
    localparam int N_MD       = 4;
    localparam int N_CORNER   = 5;
    localparam int MIN_STALL  = `EXE_MD_CYCLES + 2; // start cycle, run, save
    localparam int NUM_OPS    = 12*N_ALU + 6*4 + 4 + 8*(N_CORNER*N_CORNER + N_MD) + 2 + 2*3 + 16;
    localparam int MAX_CYCLES = NUM_OPS * (`EXE_MD_CYCLES + 4) + 500;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     exe_valid;
    word_t    exe_pc;
    inst_id_t exe_inst_id;
    exe_fun_e exe_fun;
    word_t    op1_data;
    word_t    op2_data;
    word_t    imm_b_sext;
    word_t    imm_j_sext;
    logic     jmp_pc_flg;
    logic     jmp_reg_flg;
    logic     pipeline_flush;
    logic     exe_mem_valid;
    word_t    exe_mem_pc;
    inst_id_t exe_mem_inst_id;
    word_t    exe_mem_alu_out;
    logic     branch_taken;
    word_t    branch_target;
    logic     calc_stall_flg;

    integer   seed = 32'hefd5_3d3c;
    int       errors = 0;
    int       checks = 0;
    int       cycle_cnt = 0;
    inst_id_t next_id = 64'd1;
    logic     exp_active = 1'b0;    // low while no output may be accepted
    logic     exp_check_alu = 1'b0;
    word_t    exp_result;
    logic     exp_taken;
    word_t    exp_target;
    word_t    corner_vals [N_CORNER] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    always #50 clk = ~clk;

    exe_core exe_core_inst (.*);

    function automatic void exe_ref(
        input  exe_fun_e fun,
        input  word_t    a,
        input  word_t    b,
        input  word_t    pc,
        input  word_t    imm_b,
        input  word_t    imm_j,
        input  logic     jpc,
        input  logic     jreg,
        output word_t    res,
        output logic     taken,
        output word_t    target
    );
        int   sa;
        int   sb;
        logic cond;
        sa   = a;
        sb   = b;
        res  = '0;
        cond = 1'b0;
        case (fun)
            ADD:    res = a + b;
            SUB:    res = a - b;
            AND:    res = a & b;
            OR:     res = a | b;
            XOR:    res = a ^ b;
            SLL:    res = a << b[4:0];
            SRL:    res = a >> b[4:0];
            SRA:    res = word_t'(sa >>> b[4:0]);
            SLT:    res = (sa < sb) ? 32'd1 : 32'd0;
            SLTU:   res = (a < b) ? 32'd1 : 32'd0;
            JALR:   res = (a + b) & 32'hffff_fffe;
            COPY1:  res = a;
            BEQ:    cond = a == b;
            BNE:    cond = a != b;
            BLT:    cond = sa < sb;
            BGE:    cond = sa >= sb;
            BLTU:   cond = a < b;
            BGEU:   cond = a >= b;
            MUL:    res = a * b;
            MULH:   res = word_t'((longint'(sa) * longint'(sb)) >>> 32);
            MULHU:  res = word_t'(({32'h0, a} * {32'h0, b}) >> 32);
            MULHSU: res = word_t'((longint'(sa) * longint'({32'h0, b})) >>> 32);
            // 64 bit math gives the wrapped result for min / -1
            DIV:    res = (b == '0) ? '1 : word_t'(longint'(sa) / longint'(sb));
            DIVU:   res = (b == '0) ? '1 : a / b;
            REM:    res = (b == '0) ? a : word_t'(longint'(sa) % longint'(sb));
            REMU:   res = (b == '0) ? a : a % b;
            default: res = '0;
        endcase
        taken  = jpc || jreg || cond;
        target = jpc ? pc + imm_j : (jreg ? a + b : pc + imm_b);
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // holds one instruction until it is accepted
    task automatic issue_op(input exe_fun_e fun, input word_t a, input word_t b,
                            input logic jpc, input logic jreg);
        int   stall_cnt;
        logic accepted;
        stall_cnt   = 0;
        accepted    = 1'b0;
        exe_valid   = 1'b1;
        exe_fun     = fun;
        op1_data    = a;
        op2_data    = b;
        exe_pc      = word_t'($random(seed)) & ~32'h3;
        imm_b_sext  = word_t'($random(seed));
        imm_j_sext  = word_t'($random(seed));
        jmp_pc_flg  = jpc;
        jmp_reg_flg = jreg;
        exe_inst_id = next_id;
        next_id++;
        exe_ref(fun, a, b, exe_pc, imm_b_sext, imm_j_sext, jpc, jreg,
                exp_result, exp_taken, exp_target);
        exp_check_alu = !(fun inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, NOP});
        exp_active    = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = exe_mem_valid && !calc_stall_flg;
            if (!accepted)
                stall_cnt++;
        end
        @(posedge clk);
        #10;
        if (fun inside {[MUL:REMU]}) begin
            if (stall_cnt < MIN_STALL) begin
                errors++;
                $display("%0t ns: stall for %s dropped after %0d cycles, before the result",
                         $time, fun.name(), stall_cnt);
            end
        end else begin
            check_value("calc_stall_flg cycles", 64'(stall_cnt), 64'd0);
        end
    endtask

    task automatic idle_cycles(input int n);
        exe_valid   = 1'b0;
        exe_fun     = BEQ;
        op1_data    = word_t'($random(seed));
        op2_data    = op1_data;   // would branch if it were valid
        jmp_pc_flg  = 1'b1;
        jmp_reg_flg = 1'b1;
        exp_active  = 1'b0;
        repeat (n) @(posedge clk);
        #10;
    endtask

    // divide killed mid-run, then another op right away
    task automatic flush_case(input exe_fun_e follow);
        exe_valid   = 1'b1;
        exe_fun     = DIV;
        op1_data    = word_t'($random(seed));
        op2_data    = word_t'($random(seed));
        jmp_pc_flg  = 1'b0;
        jmp_reg_flg = 1'b0;
        exe_inst_id = next_id;
        next_id++;
        exp_active  = 1'b0;
        repeat (10) @(posedge clk);
        #10;
        pipeline_flush = 1'b1;   // divide still valid while it is killed
        @(posedge clk);
        #10;
        pipeline_flush = 1'b0;
        issue_op(follow, word_t'($random(seed)), word_t'($random(seed)), 1'b0, 1'b0);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (!exe_valid) begin
                check_value("exe_mem_valid", 64'(exe_mem_valid), 64'd0);
                check_value("branch_taken", 64'(branch_taken), 64'd0);
            end else if (exe_mem_valid && !calc_stall_flg) begin
                if (!exp_active) begin
                    errors++;
                    $display("%0t ns: flushed instruction %0d was accepted",
                             $time, exe_mem_inst_id);
                end else begin
                    check_value("exe_mem_inst_id", exe_mem_inst_id, exe_inst_id);
                    check_value("exe_mem_pc", 64'(exe_mem_pc), 64'(exe_pc));
                    if (exp_check_alu)
                        check_value("exe_mem_alu_out", 64'(exe_mem_alu_out), 64'(exp_result));
                    check_value("branch_taken", 64'(branch_taken), 64'(exp_taken));
                    check_value("branch_target", 64'(branch_target), 64'(exp_target));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        word_t a;
        word_t b;
        rst_n          = 1'b0;
        exe_valid      = 1'b0;
        exe_pc         = '0;
        exe_inst_id    = '0;
        exe_fun        = NOP;
        op1_data       = '0;
        op2_data       = '0;
        imm_b_sext     = '0;
        imm_j_sext     = '0;
        jmp_pc_flg     = 1'b0;
        jmp_reg_flg    = 1'b0;
        pipeline_flush = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        idle_cycles(2);

        for (int f = ADD; f <= COPY1; f++)
            repeat (N_ALU)
                issue_op(exe_fun_e'(f), word_t'($random(seed)), word_t'($random(seed)),
                         1'b0, 1'b0);

        for (int f = BEQ; f <= BGEU; f++) begin
            a = word_t'($random(seed));
            issue_op(exe_fun_e'(f), a, a, 1'b0, 1'b0);
            issue_op(exe_fun_e'(f), a, a + 32'd1, 1'b0, 1'b0);
            issue_op(exe_fun_e'(f), a, a - 32'd1, 1'b0, 1'b0);
            issue_op(exe_fun_e'(f), a, ~a, 1'b0, 1'b0); // signs differ
        end
        repeat (2) begin
            issue_op(ADD, word_t'($random(seed)), 32'd4, 1'b1, 1'b0);     // jal
            issue_op(JALR, word_t'($random(seed)), word_t'($random(seed)), 1'b0, 1'b1);
        end
        idle_cycles(4);

        for (int f = MUL; f <= REMU; f++) begin
            for (int i = 0; i < N_CORNER; i++)
                for (int j = 0; j < N_CORNER; j++)
                    issue_op(exe_fun_e'(f), corner_vals[i], corner_vals[j], 1'b0, 1'b0);
            repeat (N_MD)
                issue_op(exe_fun_e'(f), word_t'($random(seed)), word_t'($random(seed)),
                         1'b0, 1'b0);
        end

        a = word_t'($random(seed));
        b = word_t'($random(seed));
        issue_op(MUL, a, b, 1'b0, 1'b0);
        issue_op(MUL, a, b, 1'b0, 1'b0);    // same operands, new id

        flush_case(MUL);
        flush_case(DIV);    // divider still busy from the flushed op
        idle_cycles(4);

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
hdl/exe_pkg.sv
hdl/seq_divider.sv
hdl/seq_multiplier.sv
hdl/execute_stage.sv
hdl/exe_core.sv
verif/tb_exe_core.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exe_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "Done: errors found" $(LOG) || ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
